// File: design/i2c_bit_timer.sv
`timescale 1ns/1ps

module i2c_bit_timer (
    input  logic                clk,
    input  logic                reset,
    input  i2c_pkg::cell_kind_t cell_kind,
    input  logic                tx_bit,
    output i2c_pkg::bit_tick_t  tick,
    output logic                scl,
    output logic                sda
);
    import i2c_pkg::*;

    logic [$clog2(i2c_quarter_cycles)-1:0] cyc_cnt;  // clocks within the quarter
    logic [1:0]                            quarter;  // quarter within the cell
    logic                                  quarter_end;
    logic                                  scl_next;
    logic                                  sda_next;
    logic                                  sda_lead;  // sda one stage before the pin

    // nothing counts while the bus is idle so a new cell always starts at quarter 0
    assign quarter_end = (cell_kind != cell_idle) &&
                         (int'(cyc_cnt) == i2c_quarter_cycles - 1);

    assign tick.tick      = quarter_end;
    assign tick.quarter   = quarter;
    assign tick.cell_done = quarter_end && (quarter == 2'd3);  // cells run back to back

    always_ff @(posedge clk) begin
        if (reset || cell_kind == cell_idle) begin
            cyc_cnt <= '0;
            quarter <= 2'd0;
        end else if (quarter_end) begin
            cyc_cnt <= '0;
            quarter <= quarter + 2'd1;  // wraps from 3 back to 0 for the next cell
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
        end
    end

    // line levels for the quarter in progress, straight from the cell table
    always_comb begin
        case (cell_kind)
            cell_start: begin
                scl_next = (quarter == 2'd1) || (quarter == 2'd2);
                sda_next = !quarter[1];  // sda falls in q2 while scl is high
            end
            cell_bit: begin
                scl_next = quarter[1];  // low for the first half, high for the second
                sda_next = tx_bit;
            end
            cell_stop: begin
                scl_next = (quarter != 2'd0);
                sda_next = quarter[1];  // sda rises in q2 while scl is high
            end
            default: begin
                scl_next = 1'b1;  // both lines released on an idle bus
                sda_next = 1'b1;
            end
        endcase
    end

    // both lines come from flops, and sda trails scl by one clock
    // so sda never moves on the same edge that scl falls at a cell boundary
    always_ff @(posedge clk) begin
        if (reset) begin
            scl      <= 1'b1;
            sda_lead <= 1'b1;
            sda      <= 1'b1;
        end else begin
            scl      <= scl_next;
            sda_lead <= sda_next;
            sda      <= sda_lead;
        end
    end

endmodule

// File: design/i2c_byte_shifter.sv
`timescale 1ns/1ps

module i2c_byte_shifter (
    input  logic                   clk,
    input  logic                   reset,
    input  i2c_pkg::bit_tick_t     tick,
    input  logic                   load,
    input  i2c_pkg::tx_frame_u     tx_frame,
    input  i2c_pkg::shift_dir_t    dir,
    input  logic                   master_ack,
    input  logic                   sda_in,
    output logic                   tx_bit,
    output logic                   frame_done,
    output i2c_pkg::frame_result_t result
);
    import i2c_pkg::*;

    byte_t      shift_q;   // msb is the bit on the bus in transmit mode
    logic [3:0] bit_cnt;   // 0 to 7 are data bits, 8 is the acknowledge bit
    logic       active;    // a frame is in progress
    shift_dir_t dir_q;
    logic       ack_q;     // level the master drives in the ninth bit of a read
    logic       sample_q;  // sda as sampled at the end of q2
    logic       ack_slot;

    assign ack_slot = (bit_cnt == 4'd8);

    // sda level for bit cells, 1 releases the line
    always_comb begin
        if (!active) begin
            tx_bit = 1'b1;
        end else if (ack_slot) begin
            tx_bit = (dir_q == dir_rx) ? ack_q : 1'b1;  // release for the peripheral ack on a write
        end else begin
            tx_bit = (dir_q == dir_tx) ? shift_q[7] : 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        frame_done <= 1'b0;
        if (reset) begin
            active  <= 1'b0;
            bit_cnt <= 4'd0;
        end else if (load) begin
            shift_q <= tx_frame.data;  // the address frame goes out as a plain byte too
            dir_q   <= dir;
            ack_q   <= master_ack;
            bit_cnt <= 4'd0;
            active  <= 1'b1;
        end else if (active && tick.tick) begin
            if (tick.quarter == 2'd2) begin
                sample_q <= sda_in;  // scl has been high for the whole of q2
            end
            if (tick.cell_done) begin
                if (ack_slot) begin
                    active          <= 1'b0;
                    frame_done      <= 1'b1;
                    result.rx_byte  <= shift_q;
                    result.ack_seen <= !sample_q;  // low on the line means acknowledged
                end else begin
                    // the bus bit shifts in while the next bit to send moves up to the msb
                    // so transmit and receive share one register
                    shift_q <= {shift_q[6:0], sample_q};
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

endmodule

// File: design/i2c_master.sv
`timescale 1ns/1ps

module i2c_master (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  i2c_pkg::i2c_request_t request,
    input  i2c_pkg::byte_t        tx_data,
    input  logic                  sda_in,
    output logic                  scl,
    output logic                  sda,
    output logic                  tx_taken,
    output i2c_pkg::byte_t        rx_data,
    output logic                  rx_valid,
    output logic                  busy,
    output logic                  done,
    output logic                  ack_error
);
    import i2c_pkg::*;

    cell_kind_t    cell_kind;   // controller tells the timer what cell comes next
    bit_tick_t     tick;        // quarter and cell strobes for controller and shifter
    tx_frame_u     tx_frame;
    shift_dir_t    dir;
    frame_result_t result;
    logic          load;
    logic          master_ack;
    logic          tx_bit;      // sda level for bit cells
    logic          frame_done;

    i2c_master_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .request    (request),
        .tx_data    (tx_data),
        .tick       (tick),
        .frame_done (frame_done),
        .result     (result),
        .cell_kind  (cell_kind),
        .load       (load),
        .tx_frame   (tx_frame),
        .dir        (dir),
        .master_ack (master_ack),
        .tx_taken   (tx_taken),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .busy       (busy),
        .done       (done),
        .ack_error  (ack_error)
    );

    i2c_bit_timer u_timer (
        .clk       (clk),
        .reset     (reset),
        .cell_kind (cell_kind),
        .tx_bit    (tx_bit),
        .tick      (tick),
        .scl       (scl),
        .sda       (sda)
    );

    i2c_byte_shifter u_shifter (
        .clk        (clk),
        .reset      (reset),
        .tick       (tick),
        .load       (load),
        .tx_frame   (tx_frame),
        .dir        (dir),
        .master_ack (master_ack),
        .sda_in     (sda_in),  // resolved bus line, own drive included
        .tx_bit     (tx_bit),
        .frame_done (frame_done),
        .result     (result)
    );

endmodule

// File: design/i2c_master_ctrl.sv
`timescale 1ns/1ps

module i2c_master_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  i2c_pkg::i2c_request_t  request,
    input  i2c_pkg::byte_t         tx_data,
    input  i2c_pkg::bit_tick_t     tick,
    input  logic                   frame_done,
    input  i2c_pkg::frame_result_t result,
    output i2c_pkg::cell_kind_t    cell_kind,
    output logic                   load,
    output i2c_pkg::tx_frame_u     tx_frame,
    output i2c_pkg::shift_dir_t    dir,
    output logic                   master_ack,
    output logic                   tx_taken,
    output i2c_pkg::byte_t         rx_data,
    output logic                   rx_valid,
    output logic                   busy,
    output logic                   done,
    output logic                   ack_error
);
    import i2c_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_address,
        st_write,
        st_read,
        st_stop
    } state_t;

    state_t                     state;
    logic [i2c_addr_width-1:0]  addr_q;
    logic [i2c_count_width-1:0] write_left;  // data bytes not yet loaded
    logic [i2c_count_width-1:0] read_left;   // read frames not yet started
    logic                       read_next;

    // the address goes out with the read bit once every write has been loaded
    assign read_next = (write_left == '0) && (read_left != '0);

    always_ff @(posedge clk) begin
        load     <= 1'b0;
        tx_taken <= 1'b0;
        rx_valid <= 1'b0;
        done     <= 1'b0;
        if (reset) begin
            state      <= st_idle;
            cell_kind  <= cell_idle;
            write_left <= '0;
            read_left  <= '0;
            busy       <= 1'b0;
            ack_error  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin  // a start pulse is only looked at here
                        addr_q     <= request.addr;
                        write_left <= request.write_count;
                        read_left  <= request.read_count;
                        ack_error  <= 1'b0;
                        busy       <= 1'b1;
                        cell_kind  <= cell_start;
                        state      <= st_start;
                    end
                end
                st_start: begin  // first start or repeated start
                    if (tick.cell_done) begin
                        cell_kind                <= cell_bit;
                        load                     <= 1'b1;
                        tx_frame.addr_frame.addr <= addr_q;
                        tx_frame.addr_frame.rw   <= read_next;
                        dir                      <= dir_tx;
                        master_ack               <= 1'b1;
                        state                    <= st_address;
                    end
                end
                st_address: begin
                    if (frame_done) begin
                        if (!result.ack_seen) begin
                            ack_error <= 1'b1;  // nobody answered the address
                            cell_kind <= cell_stop;
                            state     <= st_stop;
                        end else if (tx_frame.addr_frame.rw) begin
                            load       <= 1'b1;
                            dir        <= dir_rx;
                            master_ack <= (read_left == i2c_count_width'(1));  // refuse the last
                            read_left  <= read_left - 1'b1;
                            state      <= st_read;
                        end else if (write_left != '0) begin
                            load          <= 1'b1;
                            tx_taken      <= 1'b1;
                            tx_frame.data <= tx_data;
                            dir           <= dir_tx;
                            write_left    <= write_left - 1'b1;
                            state         <= st_write;
                        end else begin
                            cell_kind <= cell_stop;  // address only probe
                            state     <= st_stop;
                        end
                    end
                end
                st_write: begin
                    if (frame_done) begin
                        if (!result.ack_seen) begin
                            ack_error <= 1'b1;
                            cell_kind <= cell_stop;
                            state     <= st_stop;
                        end else if (write_left != '0) begin
                            load          <= 1'b1;
                            tx_taken      <= 1'b1;
                            tx_frame.data <= tx_data;
                            write_left    <= write_left - 1'b1;
                        end else if (read_left != '0) begin
                            cell_kind <= cell_start;  // repeated start before the read address
                            state     <= st_start;
                        end else begin
                            cell_kind <= cell_stop;
                            state     <= st_stop;
                        end
                    end
                end
                st_read: begin
                    if (frame_done) begin
                        rx_data  <= result.rx_byte;
                        rx_valid <= 1'b1;
                        if (read_left != '0) begin
                            load       <= 1'b1;
                            master_ack <= (read_left == i2c_count_width'(1));
                            read_left  <= read_left - 1'b1;
                        end else begin
                            cell_kind <= cell_stop;
                            state     <= st_stop;
                        end
                    end
                end
                st_stop: begin
                    if (tick.cell_done) begin
                        cell_kind <= cell_idle;
                        busy      <= 1'b0;
                        done      <= 1'b1;
                        state     <= st_idle;
                    end
                end
                default: begin
                    cell_kind <= cell_idle;
                    state     <= st_idle;
                end
            endcase
        end
    end

endmodule

// File: design/i2c_pkg.sv
package i2c_pkg;

    // bus timing, every cell is four quarters of this many clocks
    localparam int i2c_quarter_cycles = 5;

    localparam int i2c_addr_width  = 7;  // seven bit peripheral address
    localparam int i2c_count_width = 4;  // up to fifteen writes and fifteen reads

    typedef logic [7:0] byte_t;

    // line pattern the timer produces for the current cell
    typedef enum logic [1:0] {
        cell_idle,
        cell_start,
        cell_bit,
        cell_stop
    } cell_kind_t;

    typedef struct packed {
        logic       tick;       // strobes at the end of every quarter
        logic [1:0] quarter;    // quarter that is ending
        logic       cell_done;  // strobes at the end of the fourth quarter
    } bit_tick_t;

    typedef struct packed {
        logic [i2c_addr_width-1:0] addr;
        logic                      rw;  // 1 is read, 0 is write
    } addr_frame_t;

    // the shifter sends one word that is either an address frame or a data byte
    typedef union packed {
        addr_frame_t addr_frame;
        byte_t       data;
    } tx_frame_u;

    typedef enum logic {
        dir_tx,
        dir_rx
    } shift_dir_t;

    typedef struct packed {
        logic [i2c_addr_width-1:0]  addr;
        logic [i2c_count_width-1:0] write_count;
        logic [i2c_count_width-1:0] read_count;
    } i2c_request_t;

    typedef struct packed {
        byte_t rx_byte;   // the eight bits seen on the bus
        logic  ack_seen;  // peripheral held sda low in the ninth bit
    } frame_result_t;

endpackage

// File: filelist.f
design/i2c_pkg.sv
design/i2c_bit_timer.sv
design/i2c_byte_shifter.sv
design/i2c_master_ctrl.sv
design/i2c_master.sv
sim/i2c_peripheral_model.sv
sim/tb_i2c_master.sv

// File: sim/i2c_golden.txt
// addr wcnt rcnt refuse err poke | write bytes w0 to w3 | bytes the peripheral returns r0 to r3
// refuse ff is none, 00 the address, k+1 data byte k; poke 1 pulses start again while busy
52 03 00 ff 00 00  11 22 33 00  00 00 00 00
52 00 03 ff 00 00  00 00 00 00  a5 5a c3 00
52 02 02 ff 00 00  0f f0 00 00  81 7e 00 00
52 02 01 00 01 00  aa bb 00 00  00 00 00 00
52 04 00 02 01 00  de ad be ef  00 00 00 00
52 01 01 ff 00 00  99 00 00 00  66 00 00 00
52 02 02 ff 00 01  12 34 00 00  56 78 00 00
52 00 04 ff 00 00  00 00 00 00  01 80 ff 00

// File: sim/i2c_peripheral_model.sv
`timescale 1ns/1ps

module i2c_peripheral_model (
    input  logic scl,
    input  logic sda,          // resolved bus line
    output logic sda_release   // 1 leaves the line to the pull-up
);
    import i2c_pkg::*;

    logic [i2c_addr_width-1:0] my_addr;  // set by the testbench before each transaction
    int    refuse_index;                  // 0 refuses the address, k+1 refuses data byte k
    byte_t read_bytes [0:3];

    byte_t addr_log [0:3];
    byte_t data_log [0:7];
    logic  ack_log [0:7];  // 1 where the master acknowledged a read byte
    int    addr_count;
    int    data_count;
    int    ack_count;
    int    start_count;
    int    stop_count;

    byte_t shift_byte;
    byte_t send_byte;
    int    cnt;          // bit cell in the frame, -1 between a start and its first bit
    int    read_index;
    logic  active;
    logic  addr_next;    // the next frame carries an address
    logic  addr_ack;
    logic  read_mode;    // address came with the read bit and was acknowledged
    logic  sending;      // the model owns sda for the data bits of this frame
    logic  master_nack;

    task automatic clear_log();
        addr_count  = 0;
        data_count  = 0;
        ack_count   = 0;
        start_count = 0;
        stop_count  = 0;
    endtask

    initial begin
        sda_release = 1'b1;
        active      = 1'b0;
        sending     = 1'b0;
        read_mode   = 1'b0;
        cnt         = 0;
        clear_log();
    end

    // sda falling while scl is high is a start or a repeated start
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            start_count++;
            active    = 1'b1;
            addr_next = 1'b1;
            read_mode = 1'b0;
            sending   = 1'b0;
            cnt       = -1;  // the falling scl at the end of the start cell brings it to 0
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1 && active) begin
            stop_count++;  // sda rising while scl is high
            active = 1'b0;
        end
    end

    // data is valid while scl is high
    always @(posedge scl) begin
        if (active && cnt >= 0) begin
            if (cnt < 8) begin
                shift_byte = {shift_byte[6:0], sda};
            end else if (sending) begin
                master_nack = sda;  // the master answers a byte the model sent
                if (ack_count < 8) ack_log[ack_count] = !sda;
                ack_count++;
            end
        end
    end

    // sda only moves while scl is low
    always @(negedge scl) begin
        if (active) begin
            if (cnt == 7) begin
                if (sending) begin
                    sda_release = 1'b1;  // the master drives the ninth bit of a read
                end else if (addr_next) begin
                    addr_next = 1'b0;
                    addr_ack  = (shift_byte[7:1] == my_addr) && (refuse_index != 0);
                    if (addr_count < 4) addr_log[addr_count] = shift_byte;
                    addr_count++;
                    read_mode   = shift_byte[0] && addr_ack;
                    read_index  = 0;
                    sda_release = !addr_ack;
                end else begin
                    if (data_count < 8) data_log[data_count] = shift_byte;
                    data_count++;
                    sda_release = (refuse_index == data_count);  // refuse byte k when index is k+1
                end
            end else if (cnt == 8) begin
                if (read_mode && !(sending && master_nack)) begin
                    send_byte   = read_bytes[read_index];
                    read_index++;
                    sending     = 1'b1;
                    sda_release = send_byte[7];
                end else begin
                    sending     = 1'b0;
                    read_mode   = 1'b0;
                    sda_release = 1'b1;
                end
            end else if (sending && cnt >= 0) begin
                sda_release = send_byte[6 - cnt];  // msb first
            end
            cnt = (cnt == 8) ? 0 : cnt + 1;
        end
    end

endmodule

// File: sim/tb_i2c_master.sv
`timescale 1ns/1ps

module tb_i2c_master;
    import i2c_pkg::*;

    localparam int num_tests   = 8;   // lines in the golden file
    localparam int line_words  = 14;  // hex words on each golden line
    localparam int cell_cycles = 4 * i2c_quarter_cycles;

    logic         clk;
    logic         reset;
    logic         start;
    i2c_request_t request;
    byte_t        tx_data;
    wire          sda_in;
    logic         scl;
    logic         sda;
    logic         tx_taken;
    byte_t        rx_data;
    logic         rx_valid;
    logic         busy;
    logic         done;
    logic         ack_error;
    logic         sda_release;

    byte_t golden [0:num_tests*line_words-1];
    byte_t cur_writes [0:3];
    byte_t rx_log [0:7];
    int    rx_count;
    int    taken_count;
    int    done_count;
    int    cycle_count = 0;
    int    cycle_limit = 0;
    string test_name;

    assign sda_in = sda & sda_release;  // either side of the open drain bus can pull the line low

    i2c_master i_dut (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .request   (request),
        .tx_data   (tx_data),
        .sda_in    (sda_in),
        .scl       (scl),
        .sda       (sda),
        .tx_taken  (tx_taken),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .busy      (busy),
        .done      (done),
        .ack_error (ack_error)
    );

    i2c_peripheral_model i_periph (
        .scl         (scl),
        .sda         (sda_in),
        .sda_release (sda_release)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the transactions did not finish within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // each one cycle pulse from the DUT is seen once, a step after the edge that raised it
    always @(posedge clk) begin
        #1;
        if (rx_valid) begin
            if (rx_count < 8) begin
                rx_log[rx_count] = rx_data;
            end
            rx_count++;
        end
        if (done) begin
            done_count++;
        end
        if (tx_taken) begin
            taken_count++;  // the DUT has taken this byte so the next one goes up
            tx_data = (taken_count < 4) ? cur_writes[taken_count] : 8'h00;
        end
    end

    task automatic check_byte(input string what, input byte_t expected, input byte_t actual);
        if (expected !== actual) begin
            $display("error %s %s: expected %h, actual %h", test_name, what, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("error %s %s: expected %b, actual %b", test_name, what, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic pulse_start(input i2c_request_t req);
        @(posedge clk);
        #1;
        start   = 1'b1;
        request = req;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_done();
        while (done_count == 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic run_transaction(input int t);
        int           base;
        int           w;
        int           r;
        int           refuse;
        int           sent;
        int           got;
        int           starts;
        i2c_request_t req;
        i2c_request_t poke;
        base            = t * line_words;
        w               = golden[base+1];
        r               = golden[base+2];
        refuse          = golden[base+3];
        test_name       = $sformatf("transaction %0d", t);
        req.addr        = golden[base][6:0];
        req.write_count = w[3:0];
        req.read_count  = r[3:0];
        for (int i = 0; i < 4; i++) begin
            cur_writes[i]          = golden[base+6+i];
            i_periph.read_bytes[i] = golden[base+10+i];
        end
        i_periph.my_addr      = req.addr;
        i_periph.refuse_index = refuse;
        i_periph.clear_log();
        rx_count    = 0;
        taken_count = 0;
        done_count  = 0;
        @(posedge clk);
        #1 tx_data = cur_writes[0];  // the first data byte waits for the first tx_taken
        pulse_start(req);
        if (golden[base+5][0]) begin
            poke.addr        = ~req.addr;  // a different request that must not be taken
            poke.write_count = 4'd1;
            poke.read_count  = 4'd0;
            repeat (3 * cell_cycles) @(posedge clk);
            #2 check_flag("busy before the extra start", 1'b1, busy);
            pulse_start(poke);
        end
        wait_done();
        repeat (cell_cycles) @(posedge clk);  // a second done would show up in this window
        #2;
        // refusing data byte k stops after k+1 loads and a refusal in the write phase skips reads
        sent   = (refuse == 0) ? 0 : ((refuse <= w) ? refuse : w);
        got    = (refuse == 0 || refuse <= w) ? 0 : r;
        starts = (w > 0 && got > 0) ? 2 : 1;
        check_flag("ack_error", golden[base+4][0], ack_error);
        check_flag("busy after done", 1'b0, busy);
        check_byte("done pulses", 8'd1, byte_t'(done_count));
        check_byte("tx_taken pulses", byte_t'(sent), byte_t'(taken_count));
        check_byte("bytes the peripheral recorded", byte_t'(sent), byte_t'(i_periph.data_count));
        for (int i = 0; i < sent; i++) begin
            check_byte($sformatf("write byte %0d", i), cur_writes[i], i_periph.data_log[i]);
        end
        check_byte("rx_valid pulses", byte_t'(got), byte_t'(rx_count));
        check_byte("master answers", byte_t'(got), byte_t'(i_periph.ack_count));
        for (int i = 0; i < got; i++) begin
            check_byte($sformatf("read byte %0d", i), golden[base+10+i], rx_log[i]);
            check_flag($sformatf("master ack %0d", i), (i < got - 1), i_periph.ack_log[i]);
        end
        check_byte("start conditions", byte_t'(starts), byte_t'(i_periph.start_count));
        check_byte("stop conditions", 8'd1, byte_t'(i_periph.stop_count));
        check_byte("address frames", byte_t'(starts), byte_t'(i_periph.addr_count));
        check_byte("first address", {req.addr, (w == 0 && r > 0)}, i_periph.addr_log[0]);
        if (starts == 2) begin
            check_byte("repeated start address", {req.addr, 1'b1}, i_periph.addr_log[1]);
        end
    endtask

    initial begin
        int w;
        int r;
        clk         = 1'b0;
        reset       = 1'b1;
        start       = 1'b0;
        request     = '0;
        tx_data     = '0;
        rx_count    = 0;
        taken_count = 0;
        done_count  = 0;
        test_name   = "reset";
        $readmemh("sim/i2c_golden.txt", golden);
        if ($isunknown(golden[num_tests*line_words-1])) begin
            $display("the golden file sim/i2c_golden.txt could not be read completely");
            $display("ERRORS FOUND");
            $fatal(1, "no stimulus");
        end
        // start and stop cells plus nine cells per frame and one more cell and frame per repeated start
        cycle_limit = 16;
        for (int t = 0; t < num_tests; t++) begin
            w = golden[t*line_words+1];
            r = golden[t*line_words+2];
            cycle_limit += (2 + 9 * (1 + w + r) + ((w > 0 && r > 0) ? 10 : 0)) * cell_cycles;
            cycle_limit += 100;
        end
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
        for (int t = 0; t < num_tests; t++) begin
            run_transaction(t);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule
